/* flist.f */
+incdir+logic
logic/vga_pkg.sv
logic/game_pkg.sv
logic/game_regs.sv
logic/vga_timing.sv
logic/screen_selector.sv
logic/sprite_overlay.sv
logic/draw_score.sv
logic/top_game.sv
tests/tb_top_game.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_top_game -f flist.f -o sim_top_game &&
./obj_dir/sim_top_game ||
{ echo "simulation failed" >&2; exit 1; }

/* tests/tb_top_game.sv */
`timescale 1ns/100ps
`default_nettype none

`include "game_defs.svh"

module tb_top_game import game_pkg::*; ();

    localparam int FRAME   = `H_TOTAL * `V_TOTAL;
    localparam int NROWS   = 5;
    localparam int NPROBES = 6;
    localparam int LIMIT   = (NROWS * 3 + 2) * FRAME;
    localparam int ACK_MAX = 16;
    localparam int VS_LINE = `V_ACTIVE + `V_FP;     // first vsync line

    typedef struct packed {
        logic [10:0] x;
        logic [10:0] y;
        logic [11:0] rgb;
    } probe_t;

    typedef struct packed {
        g_state     state;
        logic [9:0] keeper_x;
        logic [9:0] ball_x;
        logic [9:0] ball_y;
        logic [7:0] score;      // enemy in 6:4, player in 2:0
    } row_t;

    logic        clk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        hsync;
    logic        vsync;
    logic [11:0] rgb;

    row_t        rows [NROWS];
    probe_t      probes [NROWS][NPROBES];
    logic [15:0] lfsr;
    int          cycle = 0;
    int          rises = 0;
    int          rise_cycle = 0;
    logic        vsync_prev = 1'b0;

    top_game dut (
        .clk, .arst_n,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .wb_dat_r, .wb_ack,
        .hsync, .vsync, .rgb
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    always @(posedge clk) begin
        if (cycle >= LIMIT) begin
            $display("timeout after %0d cycles, the run did not finish", cycle);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // output shape, tracked from the last vsync rise
    always @(negedge clk) begin : sync_monitor
        int d;
        int col;
        int line;
        if (arst_n && vsync && !vsync_prev) begin
            if (rises > 0) begin
                check_val("vsync period", cycle - rise_cycle, FRAME);
            end
            rise_cycle = cycle;
            rises++;
        end
        vsync_prev = vsync;
        if (rises > 0) begin
            d    = cycle - rise_cycle;
            col  = d % `H_TOTAL;
            line = (VS_LINE + d / `H_TOTAL) % `V_TOTAL;
            check_val("hsync", 32'(hsync), 32'((col >= `H_ACTIVE + `H_FP) &&
                                               (col < `H_ACTIVE + `H_FP + `H_SYNC)));
            check_val("vsync", 32'(vsync), 32'((line >= VS_LINE) &&
                                               (line < VS_LINE + `V_SYNC)));
            if (col >= `H_ACTIVE || line >= `V_ACTIVE) begin
                check_val("rgb in blanking", 32'(rgb), 0);
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wb_transfer(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
                               output logic [31:0] rdata);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            next_cycle();
            waited++;
            if (waited > ACK_MAX) begin
                $display("register slave never acknowledged address %0d", adr);
                abort_run();
            end
        end while (!wb_ack);
        rdata = wb_dat_r;
        next_cycle();                       // write lands on this edge
        check_val("wb_ack after one cycle", 32'(wb_ack), 0);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        next_cycle();
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
        logic [31:0] ignored;
        wb_transfer(1'b1, adr, data, ignored);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
        wb_transfer(1'b0, adr, 32'd0, data);
    endtask

    function automatic logic [2:0] clip_score(input logic [2:0] v);
        return (v > 3'(`MAX_SCORE)) ? 3'(`MAX_SCORE) : v;
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
    endfunction

    task automatic rand_bits(input int n, output logic [9:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[8:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [11:0] ball_rule(input int bx, input int by, input int x, input int y);
        if (x >= bx && x < bx + `BALL_SIZE && y >= by && y < by + `BALL_SIZE) begin
            return `COL_BALL;
        end
        return `COL_FIELD;
    endfunction

    task automatic set_probe(input int r, input int p, input int x, input int y,
                             input logic [11:0] c);
        probes[r][p] = '{x: 11'(x), y: 11'(y), rgb: c};
    endtask

    // probes of a row are sorted by raster order
    task automatic load_table();
        logic [9:0] bits;
        int         bx;
        int         by;
        rows[0] = '{IDLE, 10'd100, 10'd300, 10'd200, 8'h21};
        set_probe(0, 0, 10, 10, `COL_IDLE);
        set_probe(0, 1, 628, 12, `COL_IDLE);
        set_probe(0, 2, 700, 100, 12'h000);
        set_probe(0, 3, 305, 205, `COL_IDLE);
        set_probe(0, 4, 110, 405, `COL_IDLE);
        set_probe(0, 5, 320, 479, `COL_IDLE);
        rows[1] = '{KEEPER, 10'd100, 10'd120, 10'd405, 8'h32};
        set_probe(1, 0, 600, 12, `COL_ENEMY);
        set_probe(1, 1, 20, 15, `COL_PLAYER);
        set_probe(1, 2, 32, 15, `COL_FIELD);
        set_probe(1, 3, 100, 400, `COL_GLOVE);
        set_probe(1, 4, 132, 404, `COL_FIELD);
        set_probe(1, 5, 120, 405, `COL_BALL);     // ball over glove
        rows[2] = '{SHOOTER, 10'd0, 10'd8, 10'd8, 8'h05};
        set_probe(2, 0, 8, 8, `COL_PLAYER);       // marker over ball
        set_probe(2, 1, 16, 10, `COL_BALL);
        set_probe(2, 2, 60, 15, `COL_PLAYER);
        set_probe(2, 3, 68, 15, `COL_FIELD);
        set_probe(2, 4, 624, 15, `COL_FIELD);
        set_probe(2, 5, 31, 415, `COL_GLOVE);
        rows[3] = '{MATCH_END, 10'd100, 10'd120, 10'd405, 8'h77};
        set_probe(3, 0, 8, 8, `COL_PLAYER);
        set_probe(3, 1, 564, 8, `COL_END);
        set_probe(3, 2, 576, 8, `COL_ENEMY);
        set_probe(3, 3, 320, 240, `COL_END);
        set_probe(3, 4, 120, 405, `COL_END);
        set_probe(3, 5, 650, 470, 12'h000);
        // random ball, kept clear of glove and markers
        lfsr = 16'd24;
        rand_bits(8, bits);
        bx = 200 + int'(bits);
        rand_bits(8, bits);
        by = 100 + int'(bits);
        rows[4] = '{KEEPER, 10'd0, 10'(bx), 10'(by), 8'h00};
        set_probe(4, 0, bx, by - 1, ball_rule(bx, by, bx, by - 1));
        set_probe(4, 1, bx - 1, by, ball_rule(bx, by, bx - 1, by));
        set_probe(4, 2, bx, by, ball_rule(bx, by, bx, by));
        set_probe(4, 3, bx + 15, by + 15, ball_rule(bx, by, bx + 15, by + 15));
        set_probe(4, 4, bx + 16, by + 15, ball_rule(bx, by, bx + 16, by + 15));
        set_probe(4, 5, bx + 15, by + 16, ball_rule(bx, by, bx + 15, by + 16));
    endtask

    task automatic apply_row(input int r);
        logic [31:0] wr [5];
        logic [31:0] exp;
        logic [31:0] rdata;
        wr[0] = {30'd0, rows[r].state};
        wr[1] = {22'd0, rows[r].keeper_x};
        wr[2] = {22'd0, rows[r].ball_x};
        wr[3] = {22'd0, rows[r].ball_y};
        wr[4] = {24'd0, rows[r].score};
        for (int a = 0; a < 5; a++) begin
            wb_write(3'(a), wr[a]);
        end
        for (int a = 0; a < 5; a++) begin
            wb_read(3'(a), rdata);
            exp = (3'(a) == `REG_SCORE) ?
                  {25'd0, clip_score(rows[r].score[6:4]), 1'b0, clip_score(rows[r].score[2:0])} :
                  wr[a];
            check_val($sformatf("wb_dat_r at address %0d", a), rdata, exp);
        end
    endtask

    task automatic wait_vsync_rise(output int c0);
        int n;
        n = rises;
        while (rises == n) begin
            next_cycle();
        end
        c0 = rise_cycle;
    endtask

    // pixel (x,y) leaves (525 - 490 + y) * 800 + x cycles after the vsync rise
    task automatic sample_at(input int c0, input int x, input int y, input logic [11:0] exp);
        int target;
        target = c0 + (`V_TOTAL - VS_LINE + y) * `H_TOTAL + x;
        if (cycle > target) begin
            $display("pixel (%0d,%0d) had already passed when it was due for sampling", x, y);
            abort_run();
        end
        while (cycle < target) begin
            next_cycle();
        end
        check_val($sformatf("rgb at (%0d,%0d)", x, y), 32'(rgb), 32'(exp));
    endtask

    initial begin
        int          c0;
        logic [31:0] rdata;
        arst_n   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 3'd0;
        wb_dat_w = 32'd0;
        load_table();
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_val("rgb", 32'(rgb), 0);
        check_val("hsync", 32'(hsync), 0);
        check_val("vsync", 32'(vsync), 0);
        check_val("wb_ack", 32'(wb_ack), 0);

        wb_write(3'd6, 32'hffff_ffff);      // unmapped
        wb_read(3'd6, rdata);
        check_val("wb_dat_r at address 6", rdata, 0);

        for (int r = 0; r < NROWS; r++) begin
            apply_row(r);
            wait_vsync_rise(c0);
            wait_vsync_rise(c0);            // first frame skipped
            for (int p = 0; p < NPROBES; p++) begin
                sample_at(c0, int'(probes[r][p].x), int'(probes[r][p].y), probes[r][p].rgb);
            end
        end

        // state change in mid frame shows up one frame later
        wait_vsync_rise(c0);
        sample_at(c0, 600, 100, `COL_FIELD);
        wb_write(`REG_STATE, {30'd0, MATCH_END});
        sample_at(c0, 600, 300, `COL_FIELD);
        wait_vsync_rise(c0);
        sample_at(c0, 600, 100, `COL_END);

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/top_game.sv */
`timescale 1ns/100ps
`default_nettype none

`include "game_defs.svh"

module top_game import vga_pkg::*, game_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        hsync,
    output logic        vsync,
    output logic [11:0] rgb
);

    scene_t   scene;
    logic     frame_start;
    logic     show;         // sprites only during play
    vga_bus_t bus_t;
    vga_bus_t bus_bg;
    vga_bus_t bus_glove;
    vga_bus_t bus_ball;
    vga_bus_t bus_out;

    assign show = (scene.state == KEEPER) || (scene.state == SHOOTER);

    assign hsync = bus_out.hsync;
    assign vsync = bus_out.vsync;
    assign rgb   = bus_out.rgb;

    game_regs u_game_regs (
        .clk, .arst_n,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .frame_start,
        .wb_dat_r, .wb_ack,
        .scene
    );

    vga_timing u_vga_timing (.clk, .arst_n, .bus(bus_t), .frame_start);

    screen_selector u_screen_selector (
        .clk, .arst_n, .bus_in(bus_t), .scene, .bus_out(bus_bg)
    );

    sprite_overlay #(
        .SPRITE_W(`GLOVE_W), .SPRITE_H(`GLOVE_H), .SPRITE_COLOR(`COL_GLOVE)
    ) u_glove_sprite (
        .clk, .arst_n, .bus_in(bus_bg),
        .x_pos(scene.keeper_x), .y_pos(10'(`GLOVE_Y)), .show,
        .bus_out(bus_glove)
    );

    sprite_overlay #(
        .SPRITE_W(`BALL_SIZE), .SPRITE_H(`BALL_SIZE), .SPRITE_COLOR(`COL_BALL)
    ) u_ball_sprite (
        .clk, .arst_n, .bus_in(bus_glove),
        .x_pos(scene.ball_x), .y_pos(scene.ball_y), .show,
        .bus_out(bus_ball)
    );

    draw_score u_draw_score (
        .clk, .arst_n, .bus_in(bus_ball), .scene, .bus_out(bus_out)
    );

endmodule

`default_nettype wire

/* logic/draw_score.sv */
`timescale 1ns/100ps
`default_nettype none

`include "game_defs.svh"

module draw_score import vga_pkg::*, game_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  vga_bus_t bus_in,
    input  scene_t   scene,
    output vga_bus_t bus_out
);

    logic on_row;
    logic active;
    logic hit_player;
    logic hit_enemy;

    // true when h falls in the square starting at column x0
    function automatic logic in_col(input logic [10:0] h, input logic [10:0] x0);
        return (h >= x0) && (h < x0 + 11'(`SCORE_SIZE));
    endfunction

    assign on_row = (bus_in.vcount >= 11'(`SCORE_Y)) &&
                    (bus_in.vcount <  11'(`SCORE_Y + `SCORE_SIZE));
    assign active = !bus_in.hblnk && !bus_in.vblnk && (scene.state != IDLE);

    always_comb begin
        hit_player = 1'b0;
        hit_enemy  = 1'b0;
        for (int i = 0; i < `MAX_SCORE; i++) begin
            if ((3'(i) < scene.score_player) &&
                in_col(bus_in.hcount, 11'(`SCORE_X_PLAYER + i * `SCORE_PITCH))) begin
                hit_player = 1'b1;
            end
            // enemy markers run right to left
            if ((3'(i) < scene.score_enemy) &&
                in_col(bus_in.hcount, 11'(`SCORE_X_ENEMY - i * `SCORE_PITCH))) begin
                hit_enemy = 1'b1;
            end
        end
    end

    // markers go on top of everything else
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_out <= '0;
        end else begin
            bus_out <= bus_in;
            if (active && on_row && hit_player) begin
                bus_out.rgb <= `COL_PLAYER;
            end else if (active && on_row && hit_enemy) begin
                bus_out.rgb <= `COL_ENEMY;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/sprite_overlay.sv */
`timescale 1ns/100ps
`default_nettype none

module sprite_overlay import vga_pkg::*; #(
    parameter int          SPRITE_W     = 16,
    parameter int          SPRITE_H     = 16,
    parameter logic [11:0] SPRITE_COLOR = 12'hfff
) (
    input  logic       clk,
    input  logic       arst_n,
    input  vga_bus_t   bus_in,
    input  logic [9:0] x_pos,
    input  logic [9:0] y_pos,
    input  logic       show,
    output vga_bus_t   bus_out
);

    logic [10:0] x_lo;
    logic [10:0] x_hi;
    logic [10:0] y_lo;
    logic [10:0] y_hi;
    logic        in_x;
    logic        in_y;
    logic        active;
    logic        hit;

    // one extra bit so the far edge cannot wrap
    assign x_lo = {1'b0, x_pos};
    assign y_lo = {1'b0, y_pos};
    assign x_hi = x_lo + 11'(SPRITE_W);
    assign y_hi = y_lo + 11'(SPRITE_H);

    assign in_x   = (bus_in.hcount >= x_lo) && (bus_in.hcount < x_hi);
    assign in_y   = (bus_in.vcount >= y_lo) && (bus_in.vcount < y_hi);
    assign active = !bus_in.hblnk && !bus_in.vblnk;

    assign hit = show && active && in_x && in_y;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_out <= '0;
        end else begin
            bus_out <= bus_in;
            if (hit) begin
                bus_out.rgb <= SPRITE_COLOR;    // solid fill
            end
        end
    end

endmodule

`default_nettype wire

/* logic/screen_selector.sv */
`timescale 1ns/100ps
`default_nettype none

`include "game_defs.svh"

module screen_selector import vga_pkg::*, game_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  vga_bus_t bus_in,
    input  scene_t   scene,
    output vga_bus_t bus_out
);

    logic [11:0] bg_color;
    logic        blank;

    assign blank = bus_in.hblnk || bus_in.vblnk;

    always_comb begin
        case (scene.state)
            IDLE:            bg_color = `COL_IDLE;
            KEEPER, SHOOTER: bg_color = `COL_FIELD;
            default:         bg_color = `COL_END;     // MATCH_END
        endcase
    end

    // timing fields pass through, colour replaced
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_out <= '0;
        end else begin
            bus_out     <= bus_in;
            bus_out.rgb <= blank ? 12'h000 : bg_color;
        end
    end

endmodule

`default_nettype wire

/* logic/vga_timing.sv */
`timescale 1ns/100ps
`default_nettype none

`include "game_defs.svh"

module vga_timing import vga_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    output vga_bus_t bus,
    output logic     frame_start
);

    logic [10:0] hcount;
    logic [10:0] vcount;
    logic        line_end;
    logic        frame_end;

    assign line_end  = (hcount == 11'(`H_TOTAL - 1));
    assign frame_end = (vcount == 11'(`V_TOTAL - 1));

    // free-running pixel and line counters
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hcount <= '0;
            vcount <= '0;
        end else if (line_end) begin
            hcount <= '0;
            vcount <= frame_end ? 11'd0 : vcount + 11'd1;
        end else begin
            hcount <= hcount + 11'd1;
        end
    end

    always_comb begin
        bus.hcount = hcount;
        bus.vcount = vcount;
        // sync pulses sit right after the front porch
        bus.hsync  = (hcount >= 11'(`H_ACTIVE + `H_FP)) &&
                     (hcount <  11'(`H_ACTIVE + `H_FP + `H_SYNC));
        bus.vsync  = (vcount >= 11'(`V_ACTIVE + `V_FP)) &&
                     (vcount <  11'(`V_ACTIVE + `V_FP + `V_SYNC));
        bus.hblnk  = (hcount >= 11'(`H_ACTIVE));
        bus.vblnk  = (vcount >= 11'(`V_ACTIVE));
        bus.rgb    = '0;    // colour is added downstream
    end

    assign frame_start = (hcount == 11'd0) && (vcount == 11'd0);

    a_counter_range: assert property (@(posedge clk) disable iff (!arst_n)
        (hcount < 11'(`H_TOTAL)) && (vcount < 11'(`V_TOTAL)))
        else $error("vga counters out of range h=%0d v=%0d", hcount, vcount);

endmodule

`default_nettype wire

/* logic/game_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "game_defs.svh"

module game_regs import game_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    input  logic        frame_start,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output scene_t      scene
);

    g_state     state_q;
    logic [9:0] keeper_x_q;
    logic [9:0] ball_x_q;
    logic [9:0] ball_y_q;
    logic [2:0] score_player_q;
    logic [2:0] score_enemy_q;
    logic       busy;           // strobe already acknowledged
    logic       wr_en;
    logic [2:0] player_clip;
    logic [2:0] enemy_clip;

    assign wr_en = wb_ack && wb_we;

    // scores saturate at the match limit
    assign player_clip = (wb_dat_w[2:0] > 3'(`MAX_SCORE)) ? 3'(`MAX_SCORE) : wb_dat_w[2:0];
    assign enemy_clip  = (wb_dat_w[6:4] > 3'(`MAX_SCORE)) ? 3'(`MAX_SCORE) : wb_dat_w[6:4];

    // one ack per strobe, then wait for stb to drop
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
            busy   <= 1'b0;
        end else begin
            wb_ack <= wb_cyc && wb_stb && !busy;
            busy   <= wb_cyc && wb_stb;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q        <= IDLE;
            keeper_x_q     <= '0;
            ball_x_q       <= '0;
            ball_y_q       <= '0;
            score_player_q <= '0;
            score_enemy_q  <= '0;
        end else if (wr_en) begin
            case (wb_adr)
                `REG_STATE:    state_q    <= g_state'(wb_dat_w[1:0]);
                `REG_KEEPER_X: keeper_x_q <= wb_dat_w[9:0];
                `REG_BALL_X:   ball_x_q   <= wb_dat_w[9:0];
                `REG_BALL_Y:   ball_y_q   <= wb_dat_w[9:0];
                `REG_SCORE: begin
                    score_player_q <= player_clip;
                    score_enemy_q  <= enemy_clip;
                end
                default: ;  // unmapped, write dropped
            endcase
        end
    end

    always_comb begin
        case (wb_adr)
            `REG_STATE:    wb_dat_r = {30'd0, state_q};
            `REG_KEEPER_X: wb_dat_r = {22'd0, keeper_x_q};
            `REG_BALL_X:   wb_dat_r = {22'd0, ball_x_q};
            `REG_BALL_Y:   wb_dat_r = {22'd0, ball_y_q};
            `REG_SCORE:    wb_dat_r = {25'd0, score_enemy_q, 1'b0, score_player_q};
            default:       wb_dat_r = '0;
        endcase
    end

    // shadow copy, frozen for the whole frame
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scene <= '0;
        end else if (frame_start) begin
            scene.state        <= state_q;
            scene.keeper_x     <= keeper_x_q;
            scene.ball_x       <= ball_x_q;
            scene.ball_y       <= ball_y_q;
            scene.score_player <= score_player_q;
            scene.score_enemy  <= score_enemy_q;
        end
    end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack raised outside a wishbone cycle");

    a_score_limit: assert property (@(posedge clk) disable iff (!arst_n)
        (score_player_q <= 3'(`MAX_SCORE)) && (score_enemy_q <= 3'(`MAX_SCORE)) &&
        (scene.score_player <= 3'(`MAX_SCORE)) && (scene.score_enemy <= 3'(`MAX_SCORE)))
        else $error("stored score above MAX_SCORE");

endmodule

`default_nettype wire

/* logic/game_pkg.sv */
`default_nettype none

package game_pkg;

    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        KEEPER    = 2'd1,
        SHOOTER   = 2'd2,
        MATCH_END = 2'd3
    } g_state;

    // everything the colour stages need to draw one frame
    typedef struct packed {
        g_state     state;
        logic [9:0] keeper_x;       // glove left edge
        logic [9:0] ball_x;
        logic [9:0] ball_y;
        logic [2:0] score_player;
        logic [2:0] score_enemy;
    } scene_t;

endpackage

`default_nettype wire

/* logic/vga_pkg.sv */
`default_nettype none

package vga_pkg;

    // one pixel in flight between the colour stages
    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;   // high outside active columns
        logic        vblnk;   // high outside active lines
        logic [11:0] rgb;
    } vga_bus_t;

endpackage

`default_nettype wire

/* logic/game_defs.svh */
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// 640x480 at 60 Hz, one pixel per clock
`define H_ACTIVE 640
`define H_FP 16
`define H_SYNC 96
`define H_TOTAL 800

`define V_ACTIVE 480
`define V_FP 10
`define V_SYNC 2
`define V_TOTAL 525

// sprite geometry in pixels
`define GLOVE_W 32
`define GLOVE_H 16
`define GLOVE_Y 400
`define BALL_SIZE 16

// 12-bit colours, 4 bits per channel rgb
`define COL_IDLE 12'h008
`define COL_FIELD 12'h0a0
`define COL_END 12'h888
`define COL_GLOVE 12'hff0
`define COL_BALL 12'hfff
`define COL_PLAYER 12'hf00
`define COL_ENEMY 12'h00f

// score markers
`define MAX_SCORE 5
`define SCORE_Y 8
`define SCORE_SIZE 8
`define SCORE_PITCH 12
`define SCORE_X_PLAYER 8
`define SCORE_X_ENEMY 624   // enemy row grows to the left

// wishbone word addresses
`define REG_STATE 3'd0
`define REG_KEEPER_X 3'd1
`define REG_BALL_X 3'd2
`define REG_BALL_Y 3'd3
`define REG_SCORE 3'd4

`endif
